/* sim.f */
+incdir+tb
source/intr_fifo_pkg.sv
source/fifo_occupancy_counter.sv
source/fifo_shift_array.sv
source/fifo_head_match.sv
source/intr_cam_fifo.sv
tb/intr_cam_fifo_tb.sv

/* source/fifo_head_match.sv */
/*
  Combinational read side. dout is the word at index count-1 and is 0 when
  empty; mtip only considers entries below count, so popped words never match.
*/
`timescale 1ns/1ps
`default_nettype none

module fifo_head_match (
  input  intr_fifo_pkg::entry_array_t entries,
  input  intr_fifo_pkg::count_t       count,
  output intr_fifo_pkg::data_t        dout,
  output logic                        mtip
);

  import intr_fifo_pkg::*;

  // One-hot select of the oldest word
  logic [FIFO_DEPTH-1:0] head_sel;

  // Entries that currently hold queued words
  logic [FIFO_DEPTH-1:0] valid;

  // Timer code seen in the low half of an entry
  logic [FIFO_DEPTH-1:0] code_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Per-entry decode
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < FIFO_DEPTH; i++) begin : g_decode
    assign head_sel[i] = (count == count_t'(i + 1));
    assign valid[i]    = (count > count_t'(i));
    assign code_hit[i] = (entries[i][MATCH_BITS-1:0] == TIMER_INTR_CODE);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output word
  ////////////////////////////////////////////////////////////////////////////

  // AND-OR mux that gives zero when nothing is selected
  always_comb begin
    dout = '0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      dout = dout | (entries[i] & {DATA_BITS{head_sel[i]}});
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Timer interrupt pending
  ////////////////////////////////////////////////////////////////////////////

  assign mtip = |(valid & code_hit);

endmodule

`default_nettype wire

/* source/fifo_occupancy_counter.sv */
/*
  Push/pop acceptance and occupancy count. op is combinational from the
  strobes and the registered count; pndng and full decode that count.
*/
`timescale 1ns/1ps
`default_nettype none

module fifo_occupancy_counter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     push,
  input  logic                     pop,
  output intr_fifo_pkg::fifo_op_e  op,
  output intr_fifo_pkg::count_t    count,
  output logic                     pndng,
  output logic                     full
);

  import intr_fifo_pkg::*;

  logic is_empty;
  logic is_full;

  ////////////////////////////////////////////////////////////////////////////
  // Status decode
  ////////////////////////////////////////////////////////////////////////////

  assign is_empty = (count == '0);
  assign is_full  = (count == count_t'(FIFO_DEPTH));

  assign pndng = ~is_empty;
  assign full  = is_full;

  ////////////////////////////////////////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////////////////////////////////////////

  // All acceptance rules live here so the datapath never looks at full/empty
  always_comb begin
    op = op_idle;
    case ({push, pop})
      2'b11: begin
        // Pop on an empty queue is ignored and the push still goes in
        if (is_empty) begin
          op = op_push;
        end else begin
          op = op_push_pop;
        end
      end
      2'b10: begin
        // Overfilling push is dropped
        if (!is_full) begin
          op = op_push;
        end
      end
      2'b01: begin
        if (!is_empty) begin
          op = op_pop;
        end
      end
      default: begin
        op = op_idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Occupancy register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      case (op)
        op_push: count <= count + count_t'(1);
        op_pop:  count <= count - count_t'(1);
        // Replace or idle keeps the occupancy
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/fifo_shift_array.sv */
/*
  Register chain holding the queue words, newest in entry 0.
  Shifts only on a push-type op; a pop moves no data.
*/
`timescale 1ns/1ps
`default_nettype none

module fifo_shift_array (
  input  logic                        clk,
  input  logic                        reset,
  input  intr_fifo_pkg::fifo_op_e     op,
  input  intr_fifo_pkg::data_t        din,
  output intr_fifo_pkg::entry_array_t entries
);

  import intr_fifo_pkg::*;

  logic shift_en;

  // Replace also shifts and the oldest word falls off behind count
  assign shift_en = (op == op_push) || (op == op_push_pop);

  ////////////////////////////////////////////////////////////////////////////
  // Cascaded entry registers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < FIFO_DEPTH; i++) begin : g_entry
    if (i == 0) begin : g_head
      // Entry 0 captures the incoming word
      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          entries[i] <= '0;
        end else if (shift_en) begin
          entries[i] <= din;
        end
      end
    end else begin : g_tail
      // Each deeper entry takes its neighbour's old value
      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          entries[i] <= '0;
        end else if (shift_en) begin
          entries[i] <= entries[i-1];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/intr_cam_fifo.sv */
/*
  Interrupt FIFO with timer-code match. push/pop are plain strobes with no
  handshake; the caller must watch full and pndng. Outputs follow one edge.
*/
`timescale 1ns/1ps
`default_nettype none

module intr_cam_fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  logic                 pop,
  input  intr_fifo_pkg::data_t din,
  output intr_fifo_pkg::data_t dout,
  output logic                 pndng,
  output logic                 full,
  output logic                 mtip
);

  import intr_fifo_pkg::*;

  fifo_op_e     op;
  count_t       count;
  entry_array_t entries;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  fifo_occupancy_counter fifo_occupancy_counter_i (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (pop),
    .op    (op),
    .count (count),
    .pndng (pndng),
    .full  (full)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  fifo_shift_array fifo_shift_array_i (
    .clk     (clk),
    .reset   (reset),
    .op      (op),
    .din     (din),
    .entries (entries)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Read side and match
  ////////////////////////////////////////////////////////////////////////////

  fifo_head_match fifo_head_match_i (
    .entries (entries),
    .count   (count),
    .dout    (dout),
    .mtip    (mtip)
  );

endmodule

`default_nettype wire

/* source/intr_fifo_pkg.sv */
/*
  Shared sizes, constants and types for the interrupt controller FIFO.
  COUNT_BITS must be wide enough to hold FIFO_DEPTH itself.
*/
`default_nettype none

package intr_fifo_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Number of queue entries
  localparam int FIFO_DEPTH = 16;

  // Width of one queue word
  localparam int DATA_BITS = 32;

  // Holds 0 to FIFO_DEPTH inclusive
  localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Timer interrupt match
  ////////////////////////////////////////////////////////////////////////////

  // Low bits of each word compared against the timer code
  localparam int MATCH_BITS = 16;

  // Low-half value of a machine timer interrupt
  localparam logic [MATCH_BITS-1:0] TIMER_INTR_CODE = 16'h0080;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [DATA_BITS-1:0] data_t;

  typedef logic [COUNT_BITS-1:0] count_t;

  // Entry 0 is the newest word
  typedef data_t [FIFO_DEPTH-1:0] entry_array_t;

  // Operation accepted in the current cycle
  typedef enum logic [1:0] {
    op_idle     = 2'b00,
    op_pop      = 2'b01,
    op_push     = 2'b10,
    op_push_pop = 2'b11
  } fifo_op_e;

endpackage

`default_nettype wire

/* tb/intr_cam_fifo_model.svh */
/*
  Reference queue for the interrupt FIFO, included inside the testbench module
  after the package import. Front of model_q is the oldest word.
*/
`ifndef INTR_CAM_FIFO_MODEL_SVH
`define INTR_CAM_FIFO_MODEL_SVH

// Words currently held, oldest first
data_t model_q[$];

// Apply one rising edge worth of push/pop to the model
task automatic model_step(input logic push_s, input logic pop_s, input data_t din_s);
  if (push_s && !pop_s) begin
    // Push on a full queue is dropped
    if (model_q.size() < FIFO_DEPTH) begin
      model_q.push_back(din_s);
    end
  end else if (pop_s && !push_s) begin
    // Pop on an empty queue does nothing
    if (model_q.size() > 0) begin
      void'(model_q.pop_front());
    end
  end else if (push_s && pop_s) begin
    if (model_q.size() == 0) begin
      model_q.push_back(din_s);
    end else begin
      // Oldest word leaves, new word joins, occupancy unchanged
      void'(model_q.pop_front());
      model_q.push_back(din_s);
    end
  end
endtask

// Oldest word, or zero when empty
function automatic data_t model_head();
  if (model_q.size() == 0) begin
    return '0;
  end
  return model_q[0];
endfunction

function automatic logic model_pndng();
  return (model_q.size() != 0);
endfunction

function automatic logic model_full();
  return (model_q.size() == FIFO_DEPTH);
endfunction

// Any held word carrying the timer code in its low half
function automatic logic model_mtip();
  logic hit;
  hit = 1'b0;
  foreach (model_q[i]) begin
    if (model_q[i][MATCH_BITS-1:0] == 16'h0080) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

`endif

/* tb/intr_cam_fifo_tb.sv */
/*
  Random push/pop testbench for the interrupt FIFO, checked against a queue
  model on each falling edge. Stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none

module intr_cam_fifo_tb;

  import intr_fifo_pkg::*;

  localparam int          N_CYCLES    = 3000;
  localparam int          CLK_PERIOD  = 10;
  localparam int          WATCHDOG_NS = (N_CYCLES + 20) * CLK_PERIOD;
  localparam int          BURST_LEN   = 64;
  localparam logic [31:0] LFSR_SEED   = 32'h16fd_9428;
  // Taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  // Starts low without an edge at time zero
  logic  clk = 1'b0;
  logic  reset;
  logic  push;
  logic  pop;
  data_t din;
  data_t dout;
  logic  pndng;
  logic  full;
  logic  mtip;

  logic [31:0] lfsr_state;
  logic [1:0]  burst_mode;
  logic        full_seen;
  logic        mtip_seen;

  `include "intr_cam_fifo_model.svh"

  intr_cam_fifo intr_cam_fifo_i (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (pop),
    .din   (din),
    .dout  (dout),
    .pndng (pndng),
    .full  (full),
    .mtip  (mtip)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Mode 2 leans on push and mode 3 on pop; modes 0 and 1 are even
  task automatic make_stimulus(output logic push_n, output logic pop_n, output data_t din_n);
    logic [31:0] bits;
    draw_bits(3, bits);
    push_n = (burst_mode == 2'd3) ? (bits[2:0] == 3'd0) :
             (burst_mode == 2'd2) ? (bits[2:0] != 3'd0) : bits[0];
    draw_bits(3, bits);
    pop_n = (burst_mode == 2'd2) ? (bits[2:0] == 3'd0) :
            (burst_mode == 2'd3) ? (bits[2:0] != 3'd0) : bits[0];
    draw_bits(32, bits);
    din_n = bits;
    draw_bits(2, bits);
    if (bits[1:0] == 2'd0) begin
      din_n[MATCH_BITS-1:0] = 16'h0080;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    check_data("dout", model_head(), dout);
    check_flag("pndng", model_pndng(), pndng);
    check_flag("full", model_full(), full);
    check_flag("mtip", model_mtip(), mtip);
    if (model_full()) begin
      full_seen = 1'b1;
    end
    if (model_mtip()) begin
      mtip_seen = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic  push_n;
    logic  pop_n;
    data_t din_n;
    logic [31:0] bits;
    lfsr_state  = LFSR_SEED;
    burst_mode  = 2'd0;
    full_seen   = 1'b0;
    mtip_seen   = 1'b0;
    reset <= 1'b1;
    push  <= 1'b0;
    pop   <= 1'b0;
    din   <= '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int cycle = 0; cycle < N_CYCLES; cycle++) begin
      @(posedge clk);
      // Model sees the same strobes the DUT samples at this edge
      model_step(push, pop, din);
      if (cycle % BURST_LEN == 0) begin
        draw_bits(2, bits);
        burst_mode = bits[1:0];
      end
      make_stimulus(push_n, pop_n, din_n);
      push <= push_n;
      pop  <= pop_n;
      din  <= din_n;
    end
    // The last falling-edge compare lies before this edge
    @(posedge clk);
    if (full_seen && mtip_seen) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      if (!full_seen) begin
        $display("Error: the queue never became full during the run");
      end
      if (!mtip_seen) begin
        $display("Error: no timer interrupt word was ever held in the queue");
      end
      $display("Simulation FAILED");
      $fatal(1, "stimulus did not reach all cases");
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Error: simulation hung, watchdog time expired");
    $display("Simulation FAILED");
    $fatal(1, "watchdog");
  end

endmodule

`default_nettype wire
